/* decode_stage.f */
decode_pkg.sv
exi_tracker.sv
imm_builder.sv
insn_decoder.sv
decode_stage.sv
decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode_stage.f \
	--top-module decode_stage_tb -o sim_decode_stage

out=$(./obj_dir/sim_decode_stage)
echo "$out"

if grep -qx "TEST RESULT: PASS" <<< "$out"; then
	exit 0
fi
exit 1

/* decode_stage_tb.sv */
// ======================================================================
// Self-checking testbench for the decode stage.
// Words are driven on the falling edge. Expected records are queued
// one cycle ahead and compared just after each rising edge.
// deco holds while out_valid is low and is compared every cycle.
// ======================================================================

`timescale 1ns/1ps

module decode_stage_tb
	import decode_pkg::*;
;

	typedef struct packed {
		logic  valid;
		deco_t d;
	} expect_t;

	logic  clk;
	logic  rst_n;
	logic  in_valid;
	insn_t insn;
	logic  flush;
	logic  out_valid;
	deco_t deco;

	integer    seed = 32'hf80a;
	int        errors = 0;
	int        cycles = 0;
	expect_t   exp_q[$];
	logic [6:0] legal_ops [23];
	logic [6:0] legal_funcs [9];

	// Model of the pending postfix and of the last issued record
	logic  pend_x = 1'b0;
	insn_t pend_word = '0;
	deco_t last_deco = '0;

	decode_stage DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.insn      (insn),
		.flush     (flush),
		.out_valid (out_valid),
		.deco      (deco)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic deco_t ref_decode(input insn_t w, input logic xv, input insn_t xw);
		deco_t       d;
		deco_t       raw;
		logic [12:0] fld;
		logic [12:0] bd;
		logic [31:0] sx;
		logic        has_imm;
		logic        legal;
		begin
			fld = w[31:19];
			bd = {w.func, w.rt};
			sx = {{19{fld[12]}}, fld};
			has_imm = 1'b1;
			legal = 1'b1;
			d = '0;
			d.ra = w.ra;
			d.rb = w.rb;
			d.rc = w.rb;
			d.rt = w.rt;
			d.memsz = octa;
			case (w.opcode)
			R2:
			begin
				has_imm = 1'b0;
				d.rfwr = 1'b1;
				d.mul = w.func inside {MUL, MULU};
				d.div = w.func inside {DIV, DIVU};
				legal = w.func inside {ADD, SUB, AND, OR, XOR, MUL, MULU, DIV, DIVU};
			end
			ADDI, CMPI, MULI, DIVI:
			begin
				d.rfwr = 1'b1;
				d.imm = sx;
				d.mul = (w.opcode == MULI);
				d.div = (w.opcode == DIVI);
			end
			ANDI:
			begin
				d.rfwr = 1'b1;
				d.imm = {19'h7ffff, fld};
			end
			ORI, XORI:
			begin
				d.rfwr = 1'b1;
				d.imm = {19'h0, fld};
			end
			LDB, LDBU, LDW, LDWU, LDO:
			begin
				d.ld = 1'b1;
				d.rfwr = 1'b1;
				d.imm = sx;
				d.ldz = (w.opcode == LDBU) || (w.opcode == LDWU);
			end
			STB, STW, STO:
			begin
				d.st = 1'b1;
				d.imm = sx;
				d.rc = w.rt;
				d.rt = '0;
			end
			JEQ, JNE, JLT:
			begin
				has_imm = 1'b0;
				d.jxx = 1'b1;
				d.rt = '0;
				d.jmptgt = {{18{bd[12]}}, bd, 1'b0};
			end
			JMP:
			begin
				has_imm = 1'b0;
				d.jmp = 1'b1;
				d.rfwr = (w.rt != '0);
				d.jmptgt = {{18{fld[12]}}, fld, 1'b0};
			end
			CSR:
			begin
				has_imm = 1'b0;
				d.csr = 1'b1;
				d.rfwr = 1'b1;
			end
			default:
			begin
				has_imm = 1'b0;
				if (w.opcode == RTS)
					d.rts = 1'b1;
				if (w.opcode inside {RTS, NOP, EXI})
					d.rt = '0;
				else
					legal = 1'b0;
			end
			endcase
			if (w.opcode inside {LDB, LDBU, STB})
				d.memsz = byt;
			else if (w.opcode inside {LDW, LDWU, STW})
				d.memsz = wyde;
			if (xv && has_imm)
				d.imm[31:13] = xw[25:7];
			d.multi_cycle = d.mul | d.div | d.ld | d.st;
			d.flowchg = d.jmp | d.jxx | d.rts;
			// Illegal keeps the raw fields but no unit flags
			if (!legal)
			begin
				raw = d;
				d = '0;
				d.ra = raw.ra;
				d.rb = raw.rb;
				d.rc = raw.rc;
				d.rt = raw.rt;
				d.imm = raw.imm;
				d.memsz = raw.memsz;
				d.jmptgt = raw.jmptgt;
				d.illegal = 1'b1;
			end
			return d;
		end
	endfunction

	function automatic logic is_known_op(input logic [6:0] op);
		logic known;
		known = (op == EXI);
		foreach (legal_ops[i])
			if (legal_ops[i] == op)
				known = 1'b1;
		return known;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] expv);
		if (got !== expv)
		begin
			$display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, expv);
			errors++;
		end
	endtask

	// Drives one input cycle and queues the result expected at the next edge
	task automatic drive_cycle(input logic v, input insn_t w, input logic f);
		expect_t e;
		@(negedge clk);
		in_valid = v;
		insn = w;
		flush = f;
		e.valid = v && !f && (w.opcode != EXI);
		e.d = e.valid ? ref_decode(w, pend_x, pend_word) : last_deco;
		exp_q.push_back(e);
		if (f)
			pend_x = 1'b0;
		else if (v)
		begin
			pend_x = (w.opcode == EXI);
			if (w.opcode == EXI)
				pend_word = w;
		end
		last_deco = e.d;
	endtask

	task automatic send_op(input logic [6:0] op, input logic v, input logic f);
		insn_t w;
		w = $random(seed);
		w.opcode = op;
		drive_cycle(v, w, f);
	endtask

	// Mostly legal words mixed with EXI, idle, flush and illegal codes
	task automatic random_cycle();
		int    pick;
		insn_t w;
		logic  v;
		logic  f;
		pick = $unsigned($random(seed)) % 100;
		w = $random(seed);
		v = 1'b1;
		f = 1'b0;
		if (pick < 8)
			v = 1'b0;
		else if (pick < 12)
		begin
			f = 1'b1;
			v = w.ra[0];
		end
		else if (pick < 22)
			w.opcode = EXI;
		else if (pick < 27)
		begin
			while (is_known_op(w.opcode))
				w.opcode = 7'($random(seed));
		end
		else
		begin
			w.opcode = legal_ops[5'($unsigned($random(seed)) % 23)];
			if (w.opcode == R2 && pick[0])
				w.func = legal_funcs[4'($unsigned($random(seed)) % 9)];
		end
		drive_cycle(v, w, f);
	endtask

	// ==================================================================
	// Comparing process
	// ==================================================================
	always @(posedge clk)
	begin
		expect_t e;
		#1;
		if (exp_q.size() > 0)
		begin
			e = exp_q.pop_front();
			check_field("out_valid", 32'(out_valid), 32'(e.valid));
			check_field("ra", 32'(deco.ra), 32'(e.d.ra));
			check_field("rb", 32'(deco.rb), 32'(e.d.rb));
			check_field("rc", 32'(deco.rc), 32'(e.d.rc));
			check_field("rt", 32'(deco.rt), 32'(e.d.rt));
			check_field("imm", deco.imm, e.d.imm);
			check_field("rfwr", 32'(deco.rfwr), 32'(e.d.rfwr));
			check_field("ld", 32'(deco.ld), 32'(e.d.ld));
			check_field("ldz", 32'(deco.ldz), 32'(e.d.ldz));
			check_field("st", 32'(deco.st), 32'(e.d.st));
			check_field("mul", 32'(deco.mul), 32'(e.d.mul));
			check_field("div", 32'(deco.div), 32'(e.d.div));
			check_field("multi_cycle", 32'(deco.multi_cycle), 32'(e.d.multi_cycle));
			check_field("jmp", 32'(deco.jmp), 32'(e.d.jmp));
			check_field("jxx", 32'(deco.jxx), 32'(e.d.jxx));
			check_field("rts", 32'(deco.rts), 32'(e.d.rts));
			check_field("csr", 32'(deco.csr), 32'(e.d.csr));
			check_field("flowchg", 32'(deco.flowchg), 32'(e.d.flowchg));
			check_field("illegal", 32'(deco.illegal), 32'(e.d.illegal));
			check_field("memsz", 32'(deco.memsz), 32'(e.d.memsz));
			check_field("jmptgt", deco.jmptgt, e.d.jmptgt);
		end
	end

	// Run limit covers about 900 stimulus cycles plus margin
	initial
	begin
		while (cycles < 1200)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within 1200 cycles");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==================================================================
	// Stimulus
	// ==================================================================
	initial
	begin
		insn_t w;
		legal_ops = '{R2, ADDI, CMPI, ANDI, ORI, XORI, MULI, DIVI, CSR, JMP, JEQ, JNE,
			JLT, RTS, NOP, LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO};
		legal_funcs = '{ADD, SUB, AND, OR, XOR, MUL, MULU, DIV, DIVU};
		rst_n = 1'b0;
		in_valid = 1'b0;
		insn = '0;
		flush = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Output stays zero while idle after reset
		send_op(ADDI, 1'b0, 1'b0);
		send_op(LDO, 1'b0, 1'b0);
		// Postfix merges into one instruction only
		send_op(EXI, 1'b1, 1'b0);
		send_op(ADDI, 1'b1, 1'b0);
		send_op(ADDI, 1'b1, 1'b0);
		// Second EXI replaces the first
		send_op(EXI, 1'b1, 1'b0);
		send_op(EXI, 1'b1, 1'b0);
		send_op(ANDI, 1'b1, 1'b0);
		// Held over an idle cycle
		send_op(EXI, 1'b1, 1'b0);
		send_op(ORI, 1'b0, 1'b0);
		send_op(ORI, 1'b1, 1'b0);
		// Flush cancels the postfix and drops the word
		send_op(EXI, 1'b1, 1'b0);
		send_op(XORI, 1'b1, 1'b1);
		send_op(XORI, 1'b1, 1'b0);
		// Consumed by a word without an immediate
		send_op(EXI, 1'b1, 1'b0);
		send_op(R2, 1'b1, 1'b0);
		send_op(STW, 1'b1, 1'b0);
		// Jump without a link writes no register
		w = $random(seed);
		w.opcode = JMP;
		w.rt = '0;
		drive_cycle(1'b1, w, 1'b0);

		repeat (870) random_cycle();
		send_op(NOP, 1'b0, 1'b0);
		while (exp_q.size() != 0)
			@(posedge clk);
		#2;
		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* decode_stage.sv */
// ======================================================================
// Decode stage top: EXI tracking, decode, one output register.
// No back-pressure; a word is taken on every valid cycle.
// One cycle latency from in_valid to out_valid. EXI words and
// flushed cycles give no output. deco holds its last value while
// out_valid is low and is zero from reset until the first word.
// ======================================================================

`timescale 1ns/1ps

module decode_stage
	import decode_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  insn_t insn,
	input  logic  flush,
	output logic  out_valid,
	output deco_t deco
);

	logic  x_valid;
	insn_t x_word;
	deco_t deco_c;
	logic  take;

	exi_tracker u_exi (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.insn     (insn),
		.flush    (flush),
		.x_valid  (x_valid),
		.x_word   (x_word)
	);

	insn_decoder u_dec (
		.insn    (insn),
		.x_valid (x_valid),
		.x_word  (x_word),
		.deco    (deco_c)
	);

	// Issue only real instructions that survive a flush
	assign take = in_valid && !flush && (insn.opcode != EXI);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			deco <= '0;
		end
		else
		begin
			out_valid <= take;
			if (take)
				deco <= deco_c;
		end
	end

	a_flush_kills: assert property (
		@(posedge clk) disable iff (!rst_n)
		flush |=> !out_valid
	);

endmodule

/* insn_decoder.sv */
// ======================================================================
// Combinational decode of one instruction word into a decode record.
// Unknown opcodes and unknown R2 functions set illegal and clear all
// other single-bit flags; register numbers and imm still follow the
// raw fields. memsz reads octa for anything that is not a load/store.
// An EXI word decodes as a no-op here; the stage never issues it.
// ======================================================================

`timescale 1ns/1ps

module insn_decoder
	import decode_pkg::*;
(
	input  insn_t insn,
	input  logic  x_valid,
	input  insn_t x_word,
	output deco_t deco
);

	logic [XLEN-1:0]  imm;
	logic [IMM_W-1:0] bdisp;
	logic [IMM_W-1:0] jdisp;

	imm_builder u_imm (
		.insn    (insn),
		.x_valid (x_valid),
		.x_word  (x_word),
		.imm     (imm)
	);

	// Branch displacement is split around the register fields
	assign bdisp = {insn.func, insn.rt};
	assign jdisp = insn[XLEN-1 -: IMM_W];

	always_comb
	begin
		deco = '0;
		deco.ra = insn.ra;
		deco.rb = insn.rb;
		deco.rc = insn.rb;
		deco.rt = insn.rt;
		deco.imm = imm;
		deco.memsz = octa;

		// ==============================================================
		// Per-opcode decode
		// ==============================================================
		case (insn.opcode)
		R2:
		begin
			deco.rfwr = 1'b1;
			case (insn.func)
			ADD, SUB, AND, OR, XOR:
				deco.mul = 1'b0;
			MUL, MULU:
				deco.mul = 1'b1;
			DIV, DIVU:
				deco.div = 1'b1;
			default:
				deco.illegal = 1'b1;
			endcase
		end
		ADDI, CMPI, ANDI, ORI, XORI:
			deco.rfwr = 1'b1;
		MULI:
		begin
			deco.rfwr = 1'b1;
			deco.mul = 1'b1;
		end
		DIVI:
		begin
			deco.rfwr = 1'b1;
			deco.div = 1'b1;
		end
		LDB, LDBU, LDW, LDWU, LDO:
		begin
			deco.rfwr = 1'b1;
			deco.ld = 1'b1;
			deco.ldz = (insn.opcode == LDBU) || (insn.opcode == LDWU);
			if (insn.opcode == LDB || insn.opcode == LDBU)
				deco.memsz = byt;
			else if (insn.opcode == LDW || insn.opcode == LDWU)
				deco.memsz = wyde;
		end
		STB, STW, STO:
		begin
			// Store data register travels in the rt field
			deco.st = 1'b1;
			deco.rc = insn.rt;
			deco.rt = '0;
			if (insn.opcode == STB)
				deco.memsz = byt;
			else if (insn.opcode == STW)
				deco.memsz = wyde;
		end
		JEQ, JNE, JLT:
		begin
			deco.jxx = 1'b1;
			deco.rt = '0;
			deco.jmptgt = {{(XLEN-IMM_W-1){bdisp[IMM_W-1]}}, bdisp, 1'b0};
		end
		JMP:
		begin
			// Non-zero rt is the link register
			deco.jmp = 1'b1;
			deco.rfwr = |insn.rt;
			deco.jmptgt = {{(XLEN-IMM_W-1){jdisp[IMM_W-1]}}, jdisp, 1'b0};
		end
		RTS:
		begin
			deco.rts = 1'b1;
			deco.rt = '0;
		end
		CSR:
		begin
			deco.csr = 1'b1;
			deco.rfwr = 1'b1;
		end
		EXI, NOP:
			deco.rt = '0;
		default:
			deco.illegal = 1'b1;
		endcase

		deco.multi_cycle = deco.mul | deco.div | deco.ld | deco.st;
		deco.flowchg = deco.jmp | deco.jxx | deco.rts;

		// Illegal word must not start any unit
		if (deco.illegal)
		begin
			deco.rfwr = 1'b0;
			deco.ld = 1'b0;
			deco.ldz = 1'b0;
			deco.st = 1'b0;
			deco.mul = 1'b0;
			deco.div = 1'b0;
			deco.multi_cycle = 1'b0;
			deco.jmp = 1'b0;
			deco.jxx = 1'b0;
			deco.rts = 1'b0;
			deco.csr = 1'b0;
			deco.flowchg = 1'b0;
		end

		// A word is never both a load and a store
		a_ld_st: assert (!(deco.ld && deco.st));
	end

endmodule

/* imm_builder.sv */
// ======================================================================
// Forms the 32-bit immediate of one instruction word.
// The 13-bit field is extended per opcode; formats without an
// immediate give zero and never take an EXI extension.
// With a pending EXI the upper 19 bits come from the postfix word.
// ======================================================================

`timescale 1ns/1ps

module imm_builder
	import decode_pkg::*;
(
	input  insn_t           insn,
	input  logic            x_valid,
	input  insn_t           x_word,
	output logic [XLEN-1:0] imm
);

	logic [IMM_W-1:0] fld;
	logic [XLEN-1:0]  base;
	logic             has_imm;

	// Short immediate sits in the top bits of the word
	assign fld = insn[XLEN-1 -: IMM_W];

	always_comb
	begin
		has_imm = 1'b1;
		case (insn.opcode)
		ADDI, CMPI, MULI, DIVI,
		LDB, LDBU, LDW, LDWU, LDO,
		STB, STW, STO:
			base = {{(XLEN-IMM_W){fld[IMM_W-1]}}, fld};
		// Mask constant, pad with ones
		ANDI:
			base = {{(XLEN-IMM_W){1'b1}}, fld};
		ORI, XORI:
			base = {{(XLEN-IMM_W){1'b0}}, fld};
		default:
		begin
			base = '0;
			has_imm = 1'b0;
		end
		endcase

		// Postfix supplies bits 31..13, payload starts above the opcode
		if (x_valid && has_imm)
			imm = {x_word[OPC_W +: XLEN-IMM_W], base[IMM_W-1:0]};
		else
			imm = base;
	end

endmodule

/* exi_tracker.sv */
// ======================================================================
// Holds a pending EXI constant postfix for the next real instruction.
// A newer EXI overwrites an older one that was not yet consumed.
// flush drops the pending postfix and wins over in_valid.
// ======================================================================

`timescale 1ns/1ps

module exi_tracker
	import decode_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid,
	input  insn_t insn,
	input  logic  flush,
	output logic  x_valid,
	output insn_t x_word
);

	logic is_exi;

	assign is_exi = (insn.opcode == EXI);

	// Pending flag: set by an EXI, cleared by any other valid word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			x_valid <= 1'b0;
		else if (flush)
			x_valid <= 1'b0;
		else if (in_valid)
			x_valid <= is_exi;
	end

	// Postfix payload, only meaningful while x_valid is high
	always_ff @(posedge clk)
	begin
		if (in_valid && is_exi && !flush)
			x_word <= insn;
	end

	// An accepted EXI must be offered, unchanged, to the following word
	a_exi_offered: assert property (
		@(posedge clk) disable iff (!rst_n)
		(in_valid && is_exi && !flush) |=> (x_valid && (x_word == $past(insn)))
	);

endmodule

/* decode_pkg.sv */
// ======================================================================
// Shared widths, encodings and record types for the decode stage.
// Instruction words are fixed at 32 bits and the modules take no
// parameters.
// Opcode and function values are this core's own encoding. Any
// 7-bit code not listed in opcode_e decodes as illegal.
// ======================================================================

package decode_pkg;

	localparam int XLEN  = 32;
	localparam int REG_W = 6;
	localparam int OPC_W = 7;
	// Width of the short immediate and of both displacements
	localparam int IMM_W = 13;

	// ==================================================================
	// Encodings
	// ==================================================================

	// Major opcodes
	typedef enum logic [OPC_W-1:0] {
		R2   = 7'h02,
		ADDI = 7'h04,
		CMPI = 7'h06,
		ANDI = 7'h08,
		ORI  = 7'h09,
		XORI = 7'h0A,
		MULI = 7'h0C,
		DIVI = 7'h0D,
		CSR  = 7'h0F,
		JMP  = 7'h20,
		JEQ  = 7'h26,
		JNE  = 7'h27,
		JLT  = 7'h28,
		RTS  = 7'h29,
		EXI  = 7'h35,
		NOP  = 7'h3F,
		LDB  = 7'h40,
		LDBU = 7'h41,
		LDW  = 7'h42,
		LDWU = 7'h43,
		LDO  = 7'h46,
		STB  = 7'h50,
		STW  = 7'h51,
		STO  = 7'h53
	} opcode_e;

	// Function codes of the R2 register form
	typedef enum logic [6:0] {
		ADD  = 7'h04,
		SUB  = 7'h05,
		AND  = 7'h08,
		OR   = 7'h09,
		XOR  = 7'h0A,
		MUL  = 7'h0C,
		DIV  = 7'h0D,
		MULU = 7'h0E,
		DIVU = 7'h0F
	} func_e;

	// Memory access size
	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd3
	} memsz_e;

	// ==================================================================
	// Records
	// ==================================================================

	// One instruction word, opcode in the low bits.
	// Immediate is the top 13 bits, i.e. {func, rb}
	typedef struct packed {
		logic [6:0]       func;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] ra;
		// Store source register in store formats
		logic [REG_W-1:0] rt;
		logic [OPC_W-1:0] opcode;
	} insn_t;

	// Decode record handed to the issue logic
	typedef struct packed {
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] rc;
		logic [REG_W-1:0] rt;
		logic [XLEN-1:0]  imm;
		logic             rfwr;
		logic             ld;
		logic             ldz;
		logic             st;
		logic             mul;
		logic             div;
		logic             multi_cycle;
		logic             jmp;
		logic             jxx;
		logic             rts;
		logic             csr;
		logic             flowchg;
		logic             illegal;
		memsz_e           memsz;
		logic [XLEN-1:0]  jmptgt;
	} deco_t;

endpackage
